//--- hw/llc_params.svh
`ifndef LLC_PARAMS_SVH
`define LLC_PARAMS_SVH

// set index width
`define LLC_SET_BITS 6

// number of sets addressed by the set index
`define LLC_SETS (1 << `LLC_SET_BITS)

// associativity and way index width
`define LLC_WAYS 4
`define LLC_WAY_BITS 2

// stored tag and data line widths
`define LLC_TAG_BITS 16
`define LLC_LINE_BITS 64

// one sharer bit per private cache
`define LLC_SHARERS_BITS 16

// coherence state encoding width
`define LLC_STATE_BITS 3

`endif

//--- hw/llc_geom_pkg.sv
`include "llc_params.svh"

package llc_geom_pkg;

    // set index into every way
    typedef logic [`LLC_SET_BITS-1:0] llc_set_t;

    // way index, also used for the eviction pointer
    typedef logic [`LLC_WAY_BITS-1:0] llc_way_t;

    // tag kept per line
    typedef logic [`LLC_TAG_BITS-1:0] llc_tag_t;

    // data line
    typedef logic [`LLC_LINE_BITS-1:0] line_t;

endpackage

//--- hw/llc_coh_pkg.sv
`include "llc_params.svh"

package llc_coh_pkg;

    // one bit per sharing cache
    typedef logic [`LLC_SHARERS_BITS-1:0] sharers_t;

    // directory state of a line
    typedef enum logic [`LLC_STATE_BITS-1:0] {
        INVALID   = 3'd0,
        VALID     = 3'd1,
        SHARED    = 3'd2,
        EXCLUSIVE = 3'd3,
        MODIFIED  = 3'd4
    } llc_state_t;

endpackage

//--- hw/llc_ifs.sv
`timescale 1ns/1ps
`include "llc_params.svh"

// write request fanned out to all way stores
interface llc_wr_if;
    import llc_geom_pkg::*;
    import llc_coh_pkg::*;

    llc_set_t            set;
    logic [`LLC_WAYS-1:0] fill_we;
    logic [`LLC_WAYS-1:0] meta_we;
    llc_tag_t            tag;
    line_t               line;
    llc_state_t          state;
    sharers_t            sharers;
    logic                dirty;

    modport decode (output set, fill_we, meta_we, tag, line, state, sharers, dirty);
    modport way (input set, fill_we, meta_we, tag, line, state, sharers, dirty);
endinterface

// contents of one way at the current set
interface llc_way_if;
    import llc_geom_pkg::*;
    import llc_coh_pkg::*;

    llc_tag_t   tag;
    llc_state_t state;
    logic       dirty;
    sharers_t   sharers;
    line_t      line;

    modport store (output tag, state, dirty, sharers, line);
    modport capture (input tag, state, dirty, sharers, line);
endinterface

//--- hw/llc_wr_decode.sv
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_wr_decode (
    input  llc_geom_pkg::llc_way_t   way,
    input  logic                     wr_en,
    input  logic [`LLC_WAYS-1:0]     wr_rst_flush,
    input  llc_geom_pkg::llc_set_t   set_in,
    input  llc_geom_pkg::llc_tag_t   wr_data_tag,
    input  llc_geom_pkg::line_t      wr_data_line,
    input  llc_coh_pkg::llc_state_t  wr_data_state,
    input  llc_coh_pkg::sharers_t    wr_data_sharers,
    input  logic                     wr_data_dirty_bit,
    llc_wr_if.decode                 wr
);

    // a flushed way is selected regardless of wr_en
    always_comb begin
        for (int i = 0; i < `LLC_WAYS; i++) begin
            wr.meta_we[i] = wr_rst_flush[i] || (wr_en && (way == i));
        end
    end

    // tag and line only move on a real write
    assign wr.fill_we = wr.meta_we & {`LLC_WAYS{wr_en}};

    assign wr.set     = set_in;
    assign wr.tag     = wr_data_tag;
    assign wr.line    = wr_data_line;
    assign wr.state   = wr_data_state;
    assign wr.sharers = wr_data_sharers;
    assign wr.dirty   = wr_data_dirty_bit;

    // a flush must not be combined with a fill of another way
    always_comb begin
        assert final ($onehot0(wr.fill_we))
        else $error("fill write strobes more than one way: %b", wr.fill_we);
    end

endmodule

//--- hw/llc_way_store.sv
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_way_store #(
    parameter int WAY_IDX = 0
) (
    input  logic     clk,
    llc_wr_if.way    wr,
    llc_way_if.store rd
);
    import llc_geom_pkg::*;
    import llc_coh_pkg::*;

    llc_tag_t   tag_mem[`LLC_SETS];
    line_t      line_mem[`LLC_SETS];
    llc_state_t state_mem[`LLC_SETS];
    sharers_t   sharers_mem[`LLC_SETS];
    logic       dirty_mem[`LLC_SETS];

    always_ff @(posedge clk) begin
        if (wr.fill_we[WAY_IDX]) begin
            tag_mem[wr.set]  <= wr.tag;
            line_mem[wr.set] <= wr.line;
        end
        if (wr.meta_we[WAY_IDX]) begin
            state_mem[wr.set]   <= wr.state;
            sharers_mem[wr.set] <= wr.sharers;
            dirty_mem[wr.set]   <= wr.dirty;
        end
    end

    // read side sees the pre-edge contents, so same-cycle writes stay hidden
    assign rd.tag     = tag_mem[wr.set];
    assign rd.line    = line_mem[wr.set];
    assign rd.state   = state_mem[wr.set];
    assign rd.sharers = sharers_mem[wr.set];
    assign rd.dirty   = dirty_mem[wr.set];

    // decoder must never refill a line without rewriting its metadata
    a_fill_with_meta: assert property (
        @(posedge clk) wr.fill_we[WAY_IDX] |-> wr.meta_we[WAY_IDX]
    ) else $error("way %0d filled without meta write", WAY_IDX);

endmodule

//--- hw/llc_rd_capture.sv
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_rd_capture (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rd_en,
    llc_way_if.capture              ways[`LLC_WAYS],
    output llc_geom_pkg::llc_tag_t  rd_data_tag[`LLC_WAYS],
    output llc_geom_pkg::line_t     rd_data_line[`LLC_WAYS],
    output llc_coh_pkg::llc_state_t rd_data_state[`LLC_WAYS],
    output llc_coh_pkg::sharers_t   rd_data_sharers[`LLC_WAYS],
    output logic                    rd_data_dirty_bit[`LLC_WAYS]
);
    import llc_coh_pkg::*;

    for (genvar g = 0; g < `LLC_WAYS; g++) begin : g_way
        always_ff @(posedge clk) begin
            if (reset) begin
                rd_data_tag[g]       <= '0;
                rd_data_line[g]      <= '0;
                rd_data_state[g]     <= INVALID;
                rd_data_sharers[g]   <= '0;
                rd_data_dirty_bit[g] <= 1'b0;
            end else if (rd_en) begin
                rd_data_tag[g]       <= ways[g].tag;
                rd_data_line[g]      <= ways[g].line;
                rd_data_state[g]     <= ways[g].state;
                rd_data_sharers[g]   <= ways[g].sharers;
                rd_data_dirty_bit[g] <= ways[g].dirty;
            end
        end

        // unwritten sets come back as X, anything else must decode
        a_state_legal: assert property (
            @(posedge clk) disable iff (reset)
            rd_en |=> ($isunknown(rd_data_state[g]) ||
                       rd_data_state[g] inside {INVALID, VALID, SHARED, EXCLUSIVE, MODIFIED})
        ) else $error("way %0d read an illegal state %0d", g, rd_data_state[g]);
    end

endmodule

//--- hw/llc_evict_store.sv
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_evict_store (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rd_en,
    input  llc_geom_pkg::llc_set_t set_in,
    input  logic                   wr_en_evict_way,
    input  llc_geom_pkg::llc_way_t wr_data_evict_way,
    output llc_geom_pkg::llc_way_t rd_data_evict_way
);
    import llc_geom_pkg::*;

    // next victim per set
    llc_way_t evict_mem[`LLC_SETS];

    always_ff @(posedge clk) begin
        if (wr_en_evict_way) begin
            evict_mem[set_in] <= wr_data_evict_way;
        end
    end

    // same one-cycle read timing as the way capture
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data_evict_way <= '0;
        end else if (rd_en) begin
            rd_data_evict_way <= evict_mem[set_in];
        end
    end

endmodule

//--- hw/llc_localmem.sv
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_localmem (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rd_en,
    input  llc_geom_pkg::llc_set_t  set_in,
    input  llc_geom_pkg::llc_way_t  way,
    input  logic                    wr_en,
    input  logic [`LLC_WAYS-1:0]    wr_rst_flush,
    input  logic                    wr_en_evict_way,
    input  llc_geom_pkg::llc_tag_t  wr_data_tag,
    input  llc_geom_pkg::line_t     wr_data_line,
    input  llc_coh_pkg::llc_state_t wr_data_state,
    input  llc_coh_pkg::sharers_t   wr_data_sharers,
    input  logic                    wr_data_dirty_bit,
    input  llc_geom_pkg::llc_way_t  wr_data_evict_way,
    output llc_geom_pkg::llc_tag_t  rd_data_tag[`LLC_WAYS],
    output llc_geom_pkg::line_t     rd_data_line[`LLC_WAYS],
    output llc_coh_pkg::llc_state_t rd_data_state[`LLC_WAYS],
    output llc_coh_pkg::sharers_t   rd_data_sharers[`LLC_WAYS],
    output logic                    rd_data_dirty_bit[`LLC_WAYS],
    output llc_geom_pkg::llc_way_t  rd_data_evict_way
);

    llc_wr_if  wr_bus();
    llc_way_if way_bus[`LLC_WAYS]();

    llc_wr_decode u_wr_decode (
        .way               (way),
        .wr_en             (wr_en),
        .wr_rst_flush      (wr_rst_flush),
        .set_in            (set_in),
        .wr_data_tag       (wr_data_tag),
        .wr_data_line      (wr_data_line),
        .wr_data_state     (wr_data_state),
        .wr_data_sharers   (wr_data_sharers),
        .wr_data_dirty_bit (wr_data_dirty_bit),
        .wr                (wr_bus.decode)
    );

    for (genvar g = 0; g < `LLC_WAYS; g++) begin : g_way
        llc_way_store #(.WAY_IDX(g)) u_way_store (
            .clk (clk),
            .wr  (wr_bus.way),
            .rd  (way_bus[g].store)
        );
    end

    llc_rd_capture u_rd_capture (
        .clk               (clk),
        .reset             (reset),
        .rd_en             (rd_en),
        .ways              (way_bus),
        .rd_data_tag       (rd_data_tag),
        .rd_data_line      (rd_data_line),
        .rd_data_state     (rd_data_state),
        .rd_data_sharers   (rd_data_sharers),
        .rd_data_dirty_bit (rd_data_dirty_bit)
    );

    llc_evict_store u_evict_store (
        .clk               (clk),
        .reset             (reset),
        .rd_en             (rd_en),
        .set_in            (set_in),
        .wr_en_evict_way   (wr_en_evict_way),
        .wr_data_evict_way (wr_data_evict_way),
        .rd_data_evict_way (rd_data_evict_way)
    );

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD       = 4.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // held over RESET_CYCLES rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- tb/tb_localmem.sv
`timescale 1ns/1ps
`include "llc_params.svh"

module tb_localmem;
    import llc_geom_pkg::*;
    import llc_coh_pkg::*;

    localparam int RESET_TIMEOUT = 20;
    localparam int N_FILLS       = 24;

    logic                 clk;
    logic                 reset;
    logic                 rd_en;
    logic                 wr_en;
    logic                 wr_en_evict_way;
    logic                 wr_data_dirty_bit;
    logic [`LLC_WAYS-1:0] wr_rst_flush;
    llc_set_t             set_in;
    llc_way_t             way;
    llc_way_t             wr_data_evict_way;
    llc_way_t             rd_data_evict_way;
    llc_tag_t             wr_data_tag;
    line_t                wr_data_line;
    llc_state_t           wr_data_state;
    sharers_t             wr_data_sharers;
    llc_tag_t             rd_data_tag[`LLC_WAYS];
    line_t                rd_data_line[`LLC_WAYS];
    llc_state_t           rd_data_state[`LLC_WAYS];
    sharers_t             rd_data_sharers[`LLC_WAYS];
    logic                 rd_data_dirty_bit[`LLC_WAYS];

    // reference storage and the expected output register
    llc_tag_t   m_tag[`LLC_WAYS][`LLC_SETS];
    line_t      m_line[`LLC_WAYS][`LLC_SETS];
    llc_state_t m_state[`LLC_WAYS][`LLC_SETS];
    sharers_t   m_sharers[`LLC_WAYS][`LLC_SETS];
    logic       m_dirty[`LLC_WAYS][`LLC_SETS];
    llc_way_t   m_evict[`LLC_SETS];
    llc_tag_t   exp_tag[`LLC_WAYS];
    line_t      exp_line[`LLC_WAYS];
    llc_state_t exp_state[`LLC_WAYS];
    sharers_t   exp_sharers[`LLC_WAYS];
    logic       exp_dirty[`LLC_WAYS];
    llc_way_t   exp_evict;

    int          check_errors = 0;
    int          timeout_errors = 0;
    logic [15:0] lfsr = 16'd26;
    logic        reset_ok;

    tb_clkgen u_clkgen (.clk(clk), .reset(reset));

    llc_localmem u_dut (.*);

    // old contents go to the output register, then the write rule applies
    always @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                exp_tag[w]     <= '0;
                exp_line[w]    <= '0;
                exp_state[w]   <= INVALID;
                exp_sharers[w] <= '0;
                exp_dirty[w]   <= 1'b0;
            end
            exp_evict <= '0;
        end else if (rd_en) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                exp_tag[w]     <= m_tag[w][set_in];
                exp_line[w]    <= m_line[w][set_in];
                exp_state[w]   <= m_state[w][set_in];
                exp_sharers[w] <= m_sharers[w][set_in];
                exp_dirty[w]   <= m_dirty[w][set_in];
            end
            exp_evict <= m_evict[set_in];
        end
        for (int w = 0; w < `LLC_WAYS; w++) begin
            if (wr_rst_flush[w] || (wr_en && way == w)) begin
                m_state[w][set_in]   <= wr_data_state;
                m_sharers[w][set_in] <= wr_data_sharers;
                m_dirty[w][set_in]   <= wr_data_dirty_bit;
                if (wr_en) begin
                    m_tag[w][set_in]  <= wr_data_tag;
                    m_line[w][set_in] <= wr_data_line;
                end
            end
        end
        if (wr_en_evict_way) begin
            m_evict[set_in] <= wr_data_evict_way;
        end
    end

    for (genvar g = 0; g < `LLC_WAYS; g++) begin : g_chk
        a_fill_match: assert property (@(posedge clk) disable iff (reset)
            rd_en |=> (rd_data_tag[g] === exp_tag[g] && rd_data_line[g] === exp_line[g])
        ) else begin
            check_errors++;
            $display("CHECK FAILED at %0t: way %0d tag %h line %h, expected %h %h", $time, g,
                     rd_data_tag[g], rd_data_line[g], exp_tag[g], exp_line[g]);
        end

        a_meta_match: assert property (@(posedge clk) disable iff (reset)
            rd_en |=> (rd_data_state[g] === exp_state[g] &&
                       rd_data_sharers[g] === exp_sharers[g] &&
                       rd_data_dirty_bit[g] === exp_dirty[g])
        ) else begin
            check_errors++;
            $display("CHECK FAILED at %0t: way %0d state/sharers/dirty differ from model",
                     $time, g);
        end

        a_hold: assert property (@(posedge clk) disable iff (reset)
            !rd_en |=> (rd_data_tag[g] === $past(rd_data_tag[g]) &&
                        rd_data_line[g] === $past(rd_data_line[g]) &&
                        rd_data_state[g] === $past(rd_data_state[g]) &&
                        rd_data_sharers[g] === $past(rd_data_sharers[g]) &&
                        rd_data_dirty_bit[g] === $past(rd_data_dirty_bit[g]))
        ) else begin
            check_errors++;
            $display("CHECK FAILED at %0t: way %0d output changed without a read", $time, g);
        end

        a_reset_clear: assert property (@(posedge clk)
            reset |=> (rd_data_tag[g] === '0 && rd_data_line[g] === '0 &&
                       rd_data_state[g] === INVALID && rd_data_sharers[g] === '0 &&
                       rd_data_dirty_bit[g] === 1'b0)
        ) else begin
            check_errors++;
            $display("CHECK FAILED at %0t: way %0d output not cleared by reset", $time, g);
        end
    end

    // the expected pointer only moves on reset or a read, so it also covers the hold
    a_evict_match: assert property (@(posedge clk)
        rd_data_evict_way === exp_evict
    ) else begin
        check_errors++;
        $display("CHECK FAILED at %0t: evict way %0d, expected %0d", $time,
                 rd_data_evict_way, exp_evict);
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function llc_state_t rand_state();
        logic [63:0] v;
        v = rand_bits(`LLC_STATE_BITS) % 5;
        return llc_state_t'(v);
    endfunction

    task next_cycle();
        @(negedge clk);
    endtask

    task load_random_data();
        wr_data_tag       = llc_tag_t'(rand_bits(`LLC_TAG_BITS));
        wr_data_line      = rand_bits(`LLC_LINE_BITS);
        wr_data_state     = rand_state();
        wr_data_sharers   = sharers_t'(rand_bits(`LLC_SHARERS_BITS));
        wr_data_dirty_bit = 1'(rand_bits(1));
    endtask

    // rd makes the read land in the same cycle as the write
    task write_way(input llc_set_t s, input int w, input logic rd);
        set_in = s;
        way    = llc_way_t'(w);
        wr_en  = 1'b1;
        rd_en  = rd;
        load_random_data();
        next_cycle();
        wr_en = 1'b0;
        rd_en = 1'b0;
    endtask

    task read_set(input llc_set_t s);
        set_in = s;
        rd_en  = 1'b1;
        next_cycle();
        rd_en = 1'b0;
    endtask

    task flush_ways(input llc_set_t s, input logic [`LLC_WAYS-1:0] mask);
        set_in       = s;
        wr_rst_flush = mask;
        load_random_data();
        next_cycle();
        wr_rst_flush = '0;
    endtask

    task write_evict(input llc_set_t s, input llc_way_t v);
        set_in            = s;
        wr_en_evict_way   = 1'b1;
        wr_data_evict_way = v;
        next_cycle();
        wr_en_evict_way = 1'b0;
    endtask

    task wait_reset_release(output logic ok);
        int n;
        n = 0;
        while (reset && n < RESET_TIMEOUT) begin
            next_cycle();
            n++;
        end
        ok = !reset;
        if (!ok) begin
            timeout_errors++;
            $display("timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
        end
    endtask

    task run_tests();
        llc_set_t sets[$];
        llc_set_t s;
        next_cycle();
        repeat (3) next_cycle();
        for (int i = 0; i < N_FILLS; i++) begin
            s = llc_set_t'(rand_bits(`LLC_SET_BITS));
            write_way(s, int'(rand_bits(`LLC_WAY_BITS)), 1'b0);
            sets.push_back(s);
        end
        foreach (sets[i]) begin
            read_set(sets[i]);
        end
        // rewrite one way of a full set
        s = llc_set_t'(rand_bits(`LLC_SET_BITS));
        for (int w = 0; w < `LLC_WAYS; w++) begin
            write_way(s, w, 1'b0);
        end
        read_set(s);
        write_way(s, 2, 1'b0);
        read_set(s);
        flush_ways(s, 4'b1010);
        read_set(s);
        flush_ways(sets[0], 4'b0111);
        read_set(sets[0]);
        // outputs hold through writes, then a same-cycle read sees old data
        write_way(s, 0, 1'b0);
        write_way(s, 1, 1'b0);
        next_cycle();
        write_way(s, 3, 1'b1);
        read_set(s);
        for (int i = 0; i < 8; i++) begin
            write_evict(llc_set_t'(i * 5), llc_way_t'(rand_bits(`LLC_WAY_BITS)));
            write_way(llc_set_t'(i * 5), int'(rand_bits(`LLC_WAY_BITS)), 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            read_set(llc_set_t'(i * 5));
        end
        repeat (3) next_cycle();
    endtask

    task finish_run();
        $display("errors: %0d check failures, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    initial begin
        rd_en             = 1'b0;
        wr_en             = 1'b0;
        wr_en_evict_way   = 1'b0;
        wr_rst_flush      = '0;
        set_in            = '0;
        way               = '0;
        wr_data_tag       = '0;
        wr_data_line      = '0;
        wr_data_state     = INVALID;
        wr_data_sharers   = '0;
        wr_data_dirty_bit = 1'b0;
        wr_data_evict_way = '0;
        wait_reset_release(reset_ok);
        if (reset_ok) begin
            run_tests();
        end
        finish_run();
    end

endmodule

//--- sim.f
+incdir+hw
hw/llc_geom_pkg.sv
hw/llc_coh_pkg.sv
hw/llc_ifs.sv
hw/llc_wr_decode.sv
hw/llc_way_store.sv
hw/llc_rd_capture.sv
hw/llc_evict_store.sv
hw/llc_localmem.sv
tb/tb_clkgen.sv
tb/tb_localmem.sv

//--- Bender.yml
package:
  name: llc_localmem

export_include_dirs:
  - hw

sources:
  - files:
      - hw/llc_geom_pkg.sv
      - hw/llc_coh_pkg.sv
      - hw/llc_ifs.sv
      - hw/llc_wr_decode.sv
      - hw/llc_way_store.sv
      - hw/llc_rd_capture.sv
      - hw/llc_evict_store.sv
      - hw/llc_localmem.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/tb_localmem.sv
